/* verilog/pkt_cfg.svh */
`ifndef PKT_CFG_SVH
`define PKT_CFG_SVH

// ------------------------------
// packet buffer sizing
// ------------------------------

// data word width
`define PKT_DATA_W      32

// longest packet in words
`define PKT_LEN_MAX     16

// length field must hold PKT_LEN_MAX itself
`define PKT_LEN_W       5

`define PKT_NUM_PORTS   2

// shared data FIFO holds two max-length packets
`define PKT_DATA_DEPTH  32
`define PKT_DESC_DEPTH  4

`endif

/* verilog/pkt_pkg.sv */
`include "pkt_cfg.svh"

package pkt_pkg;

    // one stored packet
    typedef struct packed {
        logic                   src;
        logic [`PKT_LEN_W-1:0]  length;
    } pkt_desc_t;

    // write side of the shared packet memory
    typedef struct packed {
        logic                   data_we;
        logic [`PKT_DATA_W-1:0] data;
        logic                   desc_we;
        pkt_desc_t              desc;
    } wr_bus_t;

    typedef enum logic [2:0] {
        WR_IDLE  = 3'd0,
        WR_FILL  = 3'd1,
        WR_REQ   = 3'd2,
        WR_DRAIN = 3'd3,
        WR_DESC  = 3'd4
    } wr_state_e;

    // gray-ish encoding of the egress sequencer
    typedef enum logic [2:0] {
        RD_IDLE = 3'b000,
        RD_WAIT = 3'b001,
        RD_CTRL = 3'b011,
        RD_READ = 3'b010,
        RD_DONE = 3'b110
    } rd_state_e;

endpackage

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty,
    output logic             full
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;

    assign empty = (count == '0);
    assign full  = (count == (AW+1)'(DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_data;
        if (rd_en)
            rd_data <= mem[rd_ptr];
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full));
    assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

/* verilog/in_wr_port.sv */
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module in_wr_port #(
    parameter logic PORT_ID = 1'b0
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   sop,
    input  logic                   vld,
    input  logic                   eop,
    input  logic [`PKT_DATA_W-1:0] data,
    output logic                   busy,
    output logic                   req,
    input  logic                   gnt,
    output logic                   done,
    output pkt_pkg::wr_bus_t       bus
);

    pkt_pkg::wr_state_e     state;
    pkt_pkg::wr_state_e     state_n;
    logic [`PKT_LEN_W-1:0]  len;
    logic [`PKT_LEN_W-1:0]  dcnt;
    logic                   stage_we;
    logic                   stage_re;
    logic [`PKT_DATA_W-1:0] stage_q;

    assign stage_we = vld && ((state == pkt_pkg::WR_IDLE && sop) ||
                              state == pkt_pkg::WR_FILL);

    sync_fifo #(
        .WIDTH (`PKT_DATA_W),
        .DEPTH (`PKT_LEN_MAX)
    ) stage_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (stage_we),
        .wr_data (data),
        .rd_en   (stage_re),
        .rd_data (stage_q),
        .empty   (),
        .full    ()
    );

    // ------------------------------
    // packet state
    // ------------------------------
    always_comb begin
        state_n  = state;
        stage_re = 1'b0;
        case (state)
            pkt_pkg::WR_IDLE: begin
                if (vld && sop)
                    state_n = eop ? pkt_pkg::WR_REQ : pkt_pkg::WR_FILL;
            end
            pkt_pkg::WR_FILL: begin
                if (vld && eop)
                    state_n = pkt_pkg::WR_REQ;
            end
            pkt_pkg::WR_REQ: begin
                // first staging read goes out with the grant
                if (gnt) begin
                    stage_re = 1'b1;
                    state_n  = pkt_pkg::WR_DRAIN;
                end
            end
            pkt_pkg::WR_DRAIN: begin
                if (dcnt == len - 1'b1)
                    state_n = pkt_pkg::WR_DESC;
                else
                    stage_re = 1'b1;
            end
            pkt_pkg::WR_DESC: state_n = pkt_pkg::WR_IDLE;
            default:          state_n = pkt_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pkt_pkg::WR_IDLE;
            len   <= '0;
            dcnt  <= '0;
        end else begin
            state <= state_n;
            // sop word restarts the count at one
            if (state == pkt_pkg::WR_IDLE)
                len <= {{(`PKT_LEN_W-1){1'b0}}, stage_we};
            else if (stage_we)
                len <= len + 1'b1;
            if (state == pkt_pkg::WR_REQ)
                dcnt <= '0;
            else if (state == pkt_pkg::WR_DRAIN)
                dcnt <= dcnt + 1'b1;
        end
    end

    assign busy = (state != pkt_pkg::WR_IDLE);
    assign req  = (state == pkt_pkg::WR_REQ);
    assign done = (state == pkt_pkg::WR_DESC);

    assign bus.data_we     = (state == pkt_pkg::WR_DRAIN);
    assign bus.data        = stage_q;
    assign bus.desc_we     = (state == pkt_pkg::WR_DESC);
    assign bus.desc.src    = PORT_ID;
    assign bus.desc.length = len;

    // sender keeps quiet until busy falls
    assert property (@(posedge clk) disable iff (!rst_n)
        state inside {pkt_pkg::WR_REQ, pkt_pkg::WR_DRAIN, pkt_pkg::WR_DESC} |-> !vld);

endmodule

/* verilog/wr_arbiter.sv */
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module wr_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PKT_NUM_PORTS-1:0] req,
    input  logic [`PKT_NUM_PORTS-1:0] done,
    output logic [`PKT_NUM_PORTS-1:0] gnt,
    input  pkt_pkg::wr_bus_t          bus_in [`PKT_NUM_PORTS],
    output pkt_pkg::wr_bus_t          bus_out
);

    localparam int IDX_W = (`PKT_NUM_PORTS > 1) ? $clog2(`PKT_NUM_PORTS) : 1;

    logic [IDX_W-1:0] last;
    logic [IDX_W-1:0] pick_idx;
    logic             found;

    // search starts one past the last winner
    always_comb begin
        int idx;
        found    = 1'b0;
        pick_idx = last;
        for (int i = 1; i <= `PKT_NUM_PORTS; i++) begin
            idx = (int'(last) + i) % `PKT_NUM_PORTS;
            if (!found && req[idx]) begin
                found    = 1'b1;
                pick_idx = IDX_W'(idx);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gnt  <= '0;
            last <= IDX_W'(`PKT_NUM_PORTS - 1);
        end else if (|(gnt & done)) begin
            gnt <= '0;
        end else if (gnt == '0 && found) begin
            gnt  <= {{(`PKT_NUM_PORTS-1){1'b0}}, 1'b1} << pick_idx;
            last <= pick_idx;
        end
    end

    // ------------------------------
    // write bus steering
    // ------------------------------
    always_comb begin
        bus_out = '0;
        for (int i = 0; i < `PKT_NUM_PORTS; i++) begin
            if (gnt[i])
                bus_out = bus_out | bus_in[i];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt));
    // only the owner may end a grant
    assert property (@(posedge clk) disable iff (!rst_n) |done |-> |(done & gnt));

endmodule

/* verilog/out_rd_controller.sv */
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module out_rd_controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready_in,
    input  logic                rx_valid,
    output logic                rx_ready,
    input  pkt_pkg::pkt_desc_t  desc_in,
    output pkt_pkg::pkt_desc_t  hdr,
    output logic                fifo_rd_en,
    output logic                rd_sop,
    output logic                rd_vld,
    output logic                rd_eop,
    output logic                out_sel
);

    pkt_pkg::rd_state_e    state;
    pkt_pkg::rd_state_e    state_n;
    pkt_pkg::pkt_desc_t    desc_q;
    logic                  load;
    logic                  length_add;
    logic                  length_zero;
    logic [`PKT_LEN_W-1:0] length_cnt;
    logic                  length_eq;

    // popped descriptor shows up one cycle after rx_ready
    assign load = (state == pkt_pkg::RD_CTRL);
    assign hdr  = load ? desc_in : desc_q;

    always_ff @(posedge clk) begin
        if (load)
            desc_q <= desc_in;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            length_cnt <= '0;
        else if (length_zero)
            length_cnt <= '0;
        else if (length_add)
            length_cnt <= length_cnt + 1'b1;
    end

    assign length_eq = (length_cnt == desc_q.length);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= pkt_pkg::RD_IDLE;
        else
            state <= state_n;
    end

    // ------------------------------
    // egress sequence
    // ------------------------------
    always_comb begin
        state_n     = state;
        rx_ready    = 1'b0;
        fifo_rd_en  = 1'b0;
        out_sel     = 1'b0;
        length_add  = 1'b0;
        length_zero = 1'b0;
        rd_sop      = 1'b0;
        rd_vld      = 1'b0;
        rd_eop      = 1'b0;
        case (state)
            pkt_pkg::RD_IDLE: begin
                if (ready_in)
                    state_n = pkt_pkg::RD_WAIT;
            end
            pkt_pkg::RD_WAIT: begin
                if (!ready_in) begin
                    state_n = pkt_pkg::RD_IDLE;
                end else if (rx_valid) begin
                    rx_ready = 1'b1;
                    rd_sop   = 1'b1;
                    state_n  = pkt_pkg::RD_CTRL;
                end
            end
            pkt_pkg::RD_CTRL: begin
                // header beat, first data read in flight
                rd_vld     = 1'b1;
                out_sel    = 1'b1;
                fifo_rd_en = 1'b1;
                length_add = 1'b1;
                state_n    = pkt_pkg::RD_READ;
            end
            pkt_pkg::RD_READ: begin
                rd_vld     = 1'b1;
                length_add = 1'b1;
                if (length_eq)
                    state_n = pkt_pkg::RD_DONE;
                else
                    fifo_rd_en = 1'b1;
            end
            pkt_pkg::RD_DONE: begin
                rd_eop      = 1'b1;
                length_zero = 1'b1;
                state_n     = ready_in ? pkt_pkg::RD_WAIT : pkt_pkg::RD_IDLE;
            end
            default: state_n = pkt_pkg::RD_IDLE;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        fifo_rd_en |-> state inside {pkt_pkg::RD_CTRL, pkt_pkg::RD_READ});

endmodule

/* verilog/pkt_switch_top.sv */
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module pkt_switch_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PKT_NUM_PORTS-1:0] in_sop,
    input  logic [`PKT_NUM_PORTS-1:0] in_vld,
    input  logic [`PKT_NUM_PORTS-1:0] in_eop,
    input  logic [`PKT_DATA_W-1:0]    in_data [`PKT_NUM_PORTS],
    output logic [`PKT_NUM_PORTS-1:0] in_busy,
    input  logic                      ready_in,
    output logic [`PKT_DATA_W-1:0]    out_data,
    output logic                      rd_sop,
    output logic                      rd_vld,
    output logic                      rd_eop
);

    logic [`PKT_NUM_PORTS-1:0] req;
    logic [`PKT_NUM_PORTS-1:0] gnt;
    logic [`PKT_NUM_PORTS-1:0] done;
    pkt_pkg::wr_bus_t          port_bus [`PKT_NUM_PORTS];
    pkt_pkg::wr_bus_t          mem_bus;
    logic [`PKT_DATA_W-1:0]    fifo_q;
    pkt_pkg::pkt_desc_t        desc_q;
    pkt_pkg::pkt_desc_t        hdr;
    logic                      desc_empty;
    logic                      rx_valid;
    logic                      rx_ready;
    logic                      fifo_rd_en;
    logic                      out_sel;

    // ------------------------------
    // ingress side
    // ------------------------------
    for (genvar p = 0; p < `PKT_NUM_PORTS; p++) begin : g_port
        in_wr_port #(
            .PORT_ID (1'(p))
        ) in_wr_port_i (
            .clk   (clk),
            .rst_n (rst_n),
            .sop   (in_sop[p]),
            .vld   (in_vld[p]),
            .eop   (in_eop[p]),
            .data  (in_data[p]),
            .busy  (in_busy[p]),
            .req   (req[p]),
            .gnt   (gnt[p]),
            .done  (done[p]),
            .bus   (port_bus[p])
        );
    end

    wr_arbiter wr_arbiter_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .done    (done),
        .gnt     (gnt),
        .bus_in  (port_bus),
        .bus_out (mem_bus)
    );

    // shared packet memory
    sync_fifo #(
        .WIDTH (`PKT_DATA_W),
        .DEPTH (`PKT_DATA_DEPTH)
    ) data_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (mem_bus.data_we),
        .wr_data (mem_bus.data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_q),
        .empty   (),
        .full    ()
    );

    sync_fifo #(
        .WIDTH ($bits(pkt_pkg::pkt_desc_t)),
        .DEPTH (`PKT_DESC_DEPTH)
    ) desc_fifo_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (mem_bus.desc_we),
        .wr_data (mem_bus.desc),
        .rd_en   (rx_ready),
        .rd_data (desc_q),
        .empty   (desc_empty),
        .full    ()
    );

    assign rx_valid = !desc_empty;

    // ------------------------------
    // egress side
    // ------------------------------
    out_rd_controller out_rd_controller_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready_in   (ready_in),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .desc_in    (desc_q),
        .hdr        (hdr),
        .fifo_rd_en (fifo_rd_en),
        .rd_sop     (rd_sop),
        .rd_vld     (rd_vld),
        .rd_eop     (rd_eop),
        .out_sel    (out_sel)
    );

    // header word is src and length, zero-extended
    assign out_data = out_sel ? {{(`PKT_DATA_W-$bits(hdr)){1'b0}}, hdr} : fifo_q;

endmodule

/* tb/tb_pkt_switch.sv */
`timescale 1ns/1ps
`include "pkt_cfg.svh"

module tb_pkt_switch;

    localparam int NUM_RAND = 8;

    logic                      clk;
    logic                      rst_n;
    logic [`PKT_NUM_PORTS-1:0] in_sop;
    logic [`PKT_NUM_PORTS-1:0] in_vld;
    logic [`PKT_NUM_PORTS-1:0] in_eop;
    logic [`PKT_DATA_W-1:0]    in_data [`PKT_NUM_PORTS];
    logic [`PKT_NUM_PORTS-1:0] in_busy;
    logic                      ready_in;
    logic [`PKT_DATA_W-1:0]    out_data;
    logic                      rd_sop;
    logic                      rd_vld;
    logic                      rd_eop;

    integer                 seed = 32'he15c2296;
    int                     rand_len [NUM_RAND];
    int                     timeout_limit;
    int                     expected_pkts;
    int                     cycle_cnt;
    logic [`PKT_DATA_W-1:0] exp_q0 [$];
    logic [`PKT_DATA_W-1:0] exp_q1 [$];
    logic                   src_log [$];
    bit                     sop_seen;
    bit                     in_pkt;
    int                     beats_left;
    logic                   cur_src;
    int                     sop_count;
    int                     eop_count;

    pkt_switch_top pkt_switch_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_sop   (in_sop),
        .in_vld   (in_vld),
        .in_eop   (in_eop),
        .in_data  (in_data),
        .in_busy  (in_busy),
        .ready_in (ready_in),
        .out_data (out_data),
        .rd_sop   (rd_sop),
        .rd_vld   (rd_vld),
        .rd_eop   (rd_eop)
    );

    always #4 clk = ~clk;

    // ------------------------------
    // error handling
    // ------------------------------
    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit)
            report_error($sformatf("timeout after %0d cycles", cycle_cnt));
    end

    // ------------------------------
    // scoreboard
    // ------------------------------
    // header word: src just above the length field
    function automatic logic [31:0] header_word(input int src, input int len);
        return (src << `PKT_LEN_W) | len;
    endfunction

    task automatic push_expected(input int port, input logic [31:0] w);
        if (port == 0)
            exp_q0.push_back(w);
        else
            exp_q1.push_back(w);
    endtask

    task automatic pop_expected(input logic src, output logic [31:0] w);
        w = '0;
        if (src == 1'b0) begin
            if (exp_q0.size() == 0)
                report_error("port 0 word came out with nothing expected");
            else
                w = exp_q0.pop_front();
        end else begin
            if (exp_q1.size() == 0)
                report_error("port 1 word came out with nothing expected");
            else
                w = exp_q1.pop_front();
        end
    endtask

    // sampled mid-cycle, away from the drive edge
    always @(negedge clk) begin
        logic [31:0] exp_w;
        if (rst_n) begin
            if (sop_seen && !rd_vld) begin
                report_error("no header beat right after rd_sop");
            end else if (in_pkt && beats_left != 0 && !rd_vld) begin
                report_error("data beats stopped before the packet length");
            end else if (in_pkt && beats_left == 0 && !rd_eop) begin
                report_error("rd_eop missing after the last data beat");
            end else if (rd_sop) begin
                if (in_pkt || rd_vld || rd_eop) begin
                    report_error("rd_sop inside a packet or with another strobe");
                end else begin
                    sop_seen  = 1'b1;
                    sop_count = sop_count + 1;
                end
            end else if (rd_vld) begin
                if (sop_seen) begin
                    pop_expected(out_data[`PKT_LEN_W], exp_w);
                    check_eq(out_data, exp_w, "header word");
                    cur_src    = out_data[`PKT_LEN_W];
                    beats_left = 32'(exp_w[`PKT_LEN_W-1:0]);
                    sop_seen   = 1'b0;
                    in_pkt     = 1'b1;
                    src_log.push_back(cur_src);
                end else if (in_pkt && beats_left != 0 && !rd_eop) begin
                    pop_expected(cur_src, exp_w);
                    check_eq(out_data, exp_w, "data word");
                    beats_left = beats_left - 1;
                end else begin
                    report_error("rd_vld outside the data phase of a packet");
                end
            end else if (rd_eop) begin
                if (!in_pkt) begin
                    report_error("rd_eop outside a packet");
                end else begin
                    in_pkt    = 1'b0;
                    eop_count = eop_count + 1;
                end
            end
        end
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_idle(input logic [1:0] mask);
        while (|(in_busy & mask))
            next_cycle();
    endtask

    task automatic wait_drained();
        while (exp_q0.size() != 0 || exp_q1.size() != 0 || in_pkt || sop_seen || |in_busy)
            next_cycle();
    endtask

    // busy covers request, grant, N words and the descriptor push
    task automatic check_busy_time(input int port, input int len);
        int cycles;
        cycles = 0;
        while (in_busy[port] && cycles <= len + 3) begin
            cycles = cycles + 1;
            next_cycle();
        end
        check_eq(cycles, len + 3, "in_busy cycles after the eop word");
    endtask

    // one packet per port in mask, all starting in the same cycle
    task automatic drive_packets(input logic [1:0] mask, input int len0, input int len1);
        int          n;
        int          plen;
        logic [31:0] w;
        n = (len0 > len1) ? len0 : len1;
        for (int p = 0; p < `PKT_NUM_PORTS; p++) begin
            plen = (p == 0) ? len0 : len1;
            if (mask[p])
                push_expected(p, header_word(p, plen));
        end
        for (int i = 0; i < n; i++) begin
            for (int p = 0; p < `PKT_NUM_PORTS; p++) begin
                plen = (p == 0) ? len0 : len1;
                if (mask[p] && i < plen) begin
                    w = $random(seed);
                    push_expected(p, w);
                    in_vld[p]  = 1'b1;
                    in_sop[p]  = (i == 0);
                    in_eop[p]  = (i == plen - 1);
                    in_data[p] = w;
                end else begin
                    in_vld[p] = 1'b0;
                    in_sop[p] = 1'b0;
                    in_eop[p] = 1'b0;
                end
            end
            next_cycle();
            if (i == 0)
                check_eq(in_busy & mask, mask, "in_busy after the sop word");
        end
        in_vld = '0;
        in_sop = '0;
        in_eop = '0;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic single_pkt();
        $display("test single_pkt");
        drive_packets(2'b01, 1, 1);
        check_busy_time(0, 1);
        wait_drained();
        drive_packets(2'b01, `PKT_LEN_MAX, `PKT_LEN_MAX);
        check_busy_time(0, `PKT_LEN_MAX);
        wait_drained();
    endtask

    task automatic both_ports();
        int start;
        $display("test both_ports");
        start = src_log.size();
        drive_packets(2'b11, 4, 4);
        wait_idle(2'b11);
        drive_packets(2'b11, 9, 9);
        wait_drained();
        check_eq(src_log.size(), start + 4, "packet count in both_ports");
        // first winner is the port after the last one of single_pkt
        for (int k = start; k < src_log.size(); k++) begin
            if (src_log[k] == src_log[k-1])
                report_error("grants did not alternate between the ports");
        end
    endtask

    task automatic back_to_back();
        logic [1:0] mask;
        $display("test back_to_back");
        for (int i = 0; i < NUM_RAND; i++) begin
            mask = (i % 2 == 0) ? 2'b01 : 2'b10;
            wait_idle(mask);
            drive_packets(mask, rand_len[i], rand_len[i]);
        end
        wait_drained();
    endtask

    task automatic ready_low();
        int base_sop;
        $display("test ready_low");
        ready_in = 1'b0;
        next_cycle();
        base_sop = sop_count;
        drive_packets(2'b11, 8, 6);
        wait_idle(2'b11);
        drive_packets(2'b01, 10, 10);
        wait_idle(2'b01);
        repeat (20) next_cycle();
        check_eq(sop_count, base_sop, "rd_sop count while ready_in low");
        ready_in = 1'b1;
        wait_drained();
    endtask

    task automatic ready_drop_mid();
        int base_sop;
        int base_eop;
        $display("test ready_drop_mid");
        base_sop = sop_count;
        base_eop = eop_count;
        drive_packets(2'b11, 10, 14);
        while (sop_count == base_sop)
            next_cycle();
        repeat (3) next_cycle();
        ready_in = 1'b0;
        while (eop_count == base_eop)
            next_cycle();
        repeat (10) next_cycle();
        check_eq(sop_count, base_sop + 1, "rd_sop count after ready_in drop");
        ready_in = 1'b1;
        wait_drained();
    endtask

    initial begin
        int total_words;
        clk        = 1'b0;
        rst_n      = 1'b0;
        ready_in   = 1'b1;
        in_sop     = '0;
        in_vld     = '0;
        in_eop     = '0;
        in_data[0] = '0;
        in_data[1] = '0;
        cycle_cnt  = 0;
        sop_seen   = 1'b0;
        in_pkt     = 1'b0;
        beats_left = 0;
        cur_src    = 1'b0;
        sop_count  = 0;
        eop_count  = 0;
        for (int i = 0; i < NUM_RAND; i++)
            rand_len[i] = 1 + int'({$random(seed)} % `PKT_LEN_MAX);
        // fixed lengths of single_pkt, both_ports, ready_low, ready_drop_mid
        total_words   = 1 + 16 + 2 * (4 + 9) + (8 + 6 + 10) + (10 + 14);
        expected_pkts = 11 + NUM_RAND;
        for (int i = 0; i < NUM_RAND; i++)
            total_words = total_words + rand_len[i];
        timeout_limit = 4 * (total_words + 10 * expected_pkts);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_eq(in_busy, '0, "in_busy after reset");
        single_pkt();
        both_ports();
        back_to_back();
        ready_low();
        ready_drop_mid();
        if (sop_count == expected_pkts && eop_count == expected_pkts &&
            exp_q0.size() == 0 && exp_q1.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_error("packet count or expected queues wrong at the end");
        end
    end

endmodule

/* filelist.f */
+incdir+verilog
verilog/pkt_pkg.sv
verilog/sync_fifo.sv
verilog/in_wr_port.sv
verilog/wr_arbiter.sv
verilog/out_rd_controller.sv
verilog/pkt_switch_top.sv
tb/tb_pkt_switch.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f filelist.f --top-module tb_pkt_switch \
    && ./obj_dir/Vtb_pkt_switch | tee /dev/stderr | grep -qx "PASS: all tests" \
    && echo "simulation passed" \
    && exit 0 \
    || { echo "simulation failed"; exit 1; }
